// File: source/rx_majority_defs.svh
`ifndef RX_MAJORITY_DEFS_SVH
`define RX_MAJORITY_DEFS_SVH

// Byte positions count from the first byte of a frame

// Position of the segment number's high byte; the low byte follows it
`define SEG_OFFSET 4

// Payload bytes that come right after the segment number
`define PAYLOAD_LEN 16

// One voting lane per accepted segment number
`define SEGMENT_LANES 4

`endif

// File: source/rx_frame_pkg.sv
`default_nettype none

`include "rx_majority_defs.svh"

package rx_frame_pkg;

	// One byte of the received stream
	typedef logic [7:0] byte_t;

	// Segment number as sent with the high byte first
	typedef logic [15:0] seg_num_t;

	// Position of a byte inside the payload
	typedef logic [$clog2(`PAYLOAD_LEN)-1:0] pay_idx_t;

	// Voting lane number
	typedef logic [$clog2(`SEGMENT_LANES)-1:0] lane_idx_t;

endpackage

`default_nettype wire

// File: source/rx_vote_pkg.sv
`default_nettype none

package rx_vote_pkg;

	// Copies sent per segment
	typedef enum logic [1:0] {
		vote_single = 2'd1,
		vote_triple = 2'd3
	} vote_mode_t;

	typedef logic [1:0] copy_cnt_t;

	// Unknown codes fall back to a single copy
	function automatic copy_cnt_t copies_needed(input vote_mode_t mode);
		return (mode == vote_triple) ? copy_cnt_t'(3) : copy_cnt_t'(1);
	endfunction

	// Each output bit follows at least two of the three inputs
	function automatic logic [7:0] maj3(input logic [7:0] a, input logic [7:0] b,
		input logic [7:0] c);
		return (a & b) | (a & c) | (b & c);
	endfunction

endpackage

`default_nettype wire

// File: source/rx_frame_parser.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_majority_defs.svh"

module rx_frame_parser (
	input wire rx_clk,
	input wire rst_n,
	input wire rx_enable,
	input wire rx_frame_pkg::byte_t rx_data,
	output logic pay_valid,
	output logic pay_last,
	output logic frame_abort,
	output logic loss_pulse,
	output rx_frame_pkg::byte_t pay_data,
	output rx_frame_pkg::pay_idx_t pay_index,
	output rx_frame_pkg::seg_num_t seg_num
);
	import rx_frame_pkg::*;

	localparam int PAY_START = `SEG_OFFSET + 2;
	localparam int PAY_END = PAY_START + `PAYLOAD_LEN;

	logic rx_en;
	logic rx_en_q;
	byte_t rxdata;
	logic [7:0] byte_cnt;
	byte_t seg_hi;
	logic seg_captured;
	logic pay_done;
	logic in_payload;
	logic frame_end;

	assign in_payload = rx_en && (byte_cnt >= 8'(PAY_START)) && (byte_cnt < 8'(PAY_END));

	// The registered enable has just fallen, so the frame's last byte is already decoded
	assign frame_end = rx_en_q && !rx_en;

	always_ff @(posedge rx_clk) begin
		rxdata <= rx_data;
		if (!rst_n) begin
			rx_en <= 1'b0;
			rx_en_q <= 1'b0;
			byte_cnt <= '0;
		end else begin
			rx_en <= rx_enable;
			rx_en_q <= rx_en;
			// Count indexes the byte now held in rxdata and saturates on long frames
			if (rx_en && rx_enable) begin
				if (byte_cnt != '1) begin
					byte_cnt <= byte_cnt + 8'd1;
				end
			end else begin
				byte_cnt <= '0;
			end
		end
	end

	always_ff @(posedge rx_clk) begin
		if (rx_en && byte_cnt == 8'(`SEG_OFFSET)) begin
			seg_hi <= rxdata;
		end
		if (rx_en && byte_cnt == 8'(`SEG_OFFSET + 1)) begin
			seg_num <= {seg_hi, rxdata};
		end
		pay_data <= rxdata;
		pay_index <= pay_idx_t'(byte_cnt - 8'(PAY_START));
		if (!rst_n) begin
			pay_valid <= 1'b0;
			pay_last <= 1'b0;
			seg_captured <= 1'b0;
			pay_done <= 1'b0;
			frame_abort <= 1'b0;
			loss_pulse <= 1'b0;
		end else begin
			pay_valid <= in_payload;
			pay_last <= in_payload && byte_cnt == 8'(PAY_END - 1);
			if (frame_end) begin
				seg_captured <= 1'b0;
				pay_done <= 1'b0;
			end else begin
				if (rx_en && byte_cnt == 8'(`SEG_OFFSET + 1)) begin
					seg_captured <= 1'b1;
				end
				if (in_payload && byte_cnt == 8'(PAY_END - 1)) begin
					pay_done <= 1'b1;
				end
			end
			// seg_num keeps its value here, so the router still knows the lane to abort
			loss_pulse <= frame_end && !pay_done;
			frame_abort <= frame_end && seg_captured && !pay_done;
		end
	end

	assert property (@(posedge rx_clk) disable iff (!rst_n)
		pay_valid |-> pay_index < `PAYLOAD_LEN);

	// Payload bytes of one frame leave back to back in index order
	assert property (@(posedge rx_clk) disable iff (!rst_n)
		pay_valid && pay_index != '0 |->
			$past(pay_valid) && pay_index == $past(pay_index) + 1'b1);

endmodule

`default_nettype wire

// File: source/segment_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_majority_defs.svh"

module segment_router (
	input wire rx_clk,
	input wire rst_n,
	input wire pay_valid,
	input wire pay_last,
	input wire frame_abort,
	input wire rx_frame_pkg::byte_t pay_data,
	input wire rx_frame_pkg::pay_idx_t pay_index,
	input wire rx_frame_pkg::seg_num_t seg_num,
	output logic [`SEGMENT_LANES-1:0] lane_valid,
	output logic [`SEGMENT_LANES-1:0] lane_last,
	output logic [`SEGMENT_LANES-1:0] lane_abort,
	output rx_frame_pkg::byte_t lane_data,
	output rx_frame_pkg::pay_idx_t lane_index
);
	import rx_frame_pkg::*;

	logic in_range;
	lane_idx_t lane;
	logic [`SEGMENT_LANES-1:0] lane_sel;

	assign in_range = seg_num < seg_num_t'(`SEGMENT_LANES);
	assign lane = lane_idx_t'(seg_num);

	// Out-of-range numbers select no lane and the frame disappears here
	always_comb begin
		lane_sel = '0;
		lane_sel[lane] = in_range;
	end

	always_ff @(posedge rx_clk) begin
		lane_data <= pay_data;
		lane_index <= pay_index;
		if (!rst_n) begin
			lane_valid <= '0;
			lane_last <= '0;
			lane_abort <= '0;
		end else begin
			lane_valid <= pay_valid ? lane_sel : '0;
			lane_last <= (pay_valid && pay_last) ? lane_sel : '0;
			lane_abort <= frame_abort ? lane_sel : '0;
		end
	end

endmodule

`default_nettype wire

// File: source/majority_voter.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_majority_defs.svh"

module majority_voter (
	input wire rx_clk,
	input wire rst_n,
	input wire lane_valid,
	input wire lane_last,
	input wire lane_abort,
	input wire rx_frame_pkg::byte_t lane_data,
	input wire rx_frame_pkg::pay_idx_t lane_index,
	input wire rx_vote_pkg::vote_mode_t redundancy,
	output logic vote_en,
	output rx_frame_pkg::byte_t vote_data
);
	import rx_frame_pkg::*;
	import rx_vote_pkg::*;

	// Copies 0 and 1 of the segment, indexed by payload position
	byte_t copy0 [`PAYLOAD_LEN];
	byte_t copy1 [`PAYLOAD_LEN];

	copy_cnt_t copy_cnt;
	copy_cnt_t copies;
	logic triple;
	logic final_copy;
	byte_t voted;

	assign copies = copies_needed(redundancy);
	assign triple = redundancy == vote_triple;
	assign final_copy = copy_cnt == copies - copy_cnt_t'(1);

	// The third copy is voted against the two stored bytes at the same index
	assign voted = triple ? maj3(lane_data, copy0[lane_index], copy1[lane_index]) : lane_data;

	always_ff @(posedge rx_clk) begin
		if (lane_valid && triple && !final_copy) begin
			if (copy_cnt == copy_cnt_t'(0)) begin
				copy0[lane_index] <= lane_data;
			end else begin
				copy1[lane_index] <= lane_data;
			end
		end
	end

	always_ff @(posedge rx_clk) begin
		vote_data <= voted;
		if (!rst_n) begin
			copy_cnt <= '0;
			vote_en <= 1'b0;
		end else begin
			vote_en <= lane_valid && final_copy;
			// An aborted copy never reaches lane_last and is overwritten by the next one
			if (lane_valid && lane_last) begin
				if (final_copy) begin
					copy_cnt <= '0;
				end else begin
					copy_cnt <= copy_cnt + copy_cnt_t'(1);
				end
			end
		end
	end

	// The parser aborts only after the enable has dropped, so no payload byte can coincide
	assert property (@(posedge rx_clk) disable iff (!rst_n)
		!(lane_abort && lane_valid));

endmodule

`default_nettype wire

// File: source/lane_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_majority_defs.svh"

module lane_merge (
	input wire rx_clk,
	input wire rst_n,
	input wire [`SEGMENT_LANES-1:0] vote_en,
	input wire rx_frame_pkg::byte_t vote_data [`SEGMENT_LANES],
	output logic en_out,
	output rx_frame_pkg::byte_t data_out
);
	import rx_frame_pkg::*;

	lane_idx_t sel;
	logic any_en;

	assign any_en = |vote_en;

	// Only one frame is in flight, so at most one lane speaks at a time
	always_comb begin
		sel = '0;
		for (int j = 0; j < `SEGMENT_LANES; j++) begin
			if (vote_en[j]) begin
				sel = lane_idx_t'(j);
			end
		end
	end

	always_ff @(posedge rx_clk) begin
		if (!rst_n) begin
			en_out <= 1'b0;
			data_out <= '0;
		end else begin
			en_out <= any_en;
			data_out <= any_en ? vote_data[sel] : '0;
		end
	end

	assert property (@(posedge rx_clk) disable iff (!rst_n)
		$onehot0(vote_en));

endmodule

`default_nettype wire

// File: source/rx_majority_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_majority_defs.svh"

module rx_majority_top (
	input wire rx_clk,
	input wire rst_n,
	input wire rx_enable,
	input wire rx_frame_pkg::byte_t rx_data,
	input wire rx_vote_pkg::vote_mode_t redundancy,
	output wire en_out,
	output wire loss_detected,
	output wire rx_frame_pkg::byte_t data_out
);
	import rx_frame_pkg::*;

	wire pay_valid;
	wire pay_last;
	wire frame_abort;
	wire byte_t pay_data;
	wire pay_idx_t pay_index;
	wire seg_num_t seg_num;

	wire [`SEGMENT_LANES-1:0] lane_valid;
	wire [`SEGMENT_LANES-1:0] lane_last;
	wire [`SEGMENT_LANES-1:0] lane_abort;
	wire byte_t lane_data;
	wire pay_idx_t lane_index;

	wire [`SEGMENT_LANES-1:0] vote_en;
	wire byte_t vote_data [`SEGMENT_LANES];

	rx_frame_parser u_parser (
		.rx_clk (rx_clk),
		.rst_n (rst_n),
		.rx_enable (rx_enable),
		.rx_data (rx_data),
		.pay_valid (pay_valid),
		.pay_last (pay_last),
		.frame_abort (frame_abort),
		.loss_pulse (loss_detected),
		.pay_data (pay_data),
		.pay_index (pay_index),
		.seg_num (seg_num)
	);

	segment_router u_router (
		.rx_clk (rx_clk),
		.rst_n (rst_n),
		.pay_valid (pay_valid),
		.pay_last (pay_last),
		.frame_abort (frame_abort),
		.pay_data (pay_data),
		.pay_index (pay_index),
		.seg_num (seg_num),
		.lane_valid (lane_valid),
		.lane_last (lane_last),
		.lane_abort (lane_abort),
		.lane_data (lane_data),
		.lane_index (lane_index)
	);

	for (genvar i = 0; i < `SEGMENT_LANES; i++) begin : g_lane
		majority_voter u_voter (
			.rx_clk (rx_clk),
			.rst_n (rst_n),
			.lane_valid (lane_valid[i]),
			.lane_last (lane_last[i]),
			.lane_abort (lane_abort[i]),
			.lane_data (lane_data),
			.lane_index (lane_index),
			.redundancy (redundancy),
			.vote_en (vote_en[i]),
			.vote_data (vote_data[i])
		);
	end

	lane_merge u_merge (
		.rx_clk (rx_clk),
		.rst_n (rst_n),
		.vote_en (vote_en),
		.vote_data (vote_data),
		.en_out (en_out),
		.data_out (data_out)
	);

endmodule

`default_nettype wire

// File: bench/rx_majority_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_majority_defs.svh"

module rx_majority_tb;
	import rx_frame_pkg::*;
	import rx_vote_pkg::*;

	localparam int PAY_START = `SEG_OFFSET + 2;
	localparam int FRAME_LEN = PAY_START + `PAYLOAD_LEN;
	localparam int DRAIN_LIMIT = 200;

	logic rx_clk;
	logic rst_n;
	logic rx_enable;
	byte_t rx_data;
	vote_mode_t redundancy;
	logic en_out;
	logic loss_detected;
	byte_t data_out;

	logic [31:0] lfsr_state;
	int unsigned cyc = 0;
	int unsigned exp_cyc_q[$];
	byte_t exp_data_q[$];
	int unsigned loss_q[$];
	logic exp_en;
	logic exp_loss;

	// Reference model with two stored copies and a copy count per lane
	byte_t model_copy [`SEGMENT_LANES][2][`PAYLOAD_LEN];
	int model_cnt [`SEGMENT_LANES];

	byte_t frame_pay [`PAYLOAD_LEN];
	byte_t expect_pay [`PAYLOAD_LEN];

	rx_majority_top dut_i (
		.rx_clk (rx_clk),
		.rst_n (rst_n),
		.rx_enable (rx_enable),
		.rx_data (rx_data),
		.redundancy (redundancy),
		.en_out (en_out),
		.loss_detected (loss_detected),
		.data_out (data_out)
	);

	initial begin
		rx_clk = 1'b0;
		forever #10 rx_clk = ~rx_clk;
	end

	// Counts rising edges so that expected output times are known in cycles
	always @(posedge rx_clk) begin
		cyc <= cyc + 1;
	end

	// Taps 32, 22, 2 and 1 give a maximal length sequence
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// Each result bit is set when at least two of the three input bits are set
	function automatic byte_t majority_of(input byte_t a, input byte_t b, input byte_t c);
		byte_t m;
		int ones;
		for (int i = 0; i < 8; i++) begin
			ones = int'(a[i]) + int'(b[i]) + int'(c[i]);
			m[i] = (ones >= 2);
		end
		return m;
	endfunction

	// OR with the lane count keeps the number at or above it
	function automatic seg_num_t far_seg();
		return seg_num_t'(rand_bits(16)) | seg_num_t'(`SEGMENT_LANES);
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	always @(negedge rx_clk) begin
		if (rst_n) begin
			exp_en = exp_cyc_q.size() > 0 && exp_cyc_q[0] == cyc;
			exp_loss = loss_q.size() > 0 && loss_q[0] == cyc;
			check_value("en_out", 32'(en_out), 32'(exp_en));
			check_value("loss_detected", 32'(loss_detected), 32'(exp_loss));
			if (exp_en) begin
				check_value("data_out", 32'(data_out), 32'(exp_data_q[0]));
				void'(exp_cyc_q.pop_front());
				void'(exp_data_q.pop_front());
			end else begin
				// The output byte reads as zero whenever no byte is emitted
				check_value("data_out", 32'(data_out), 32'h0);
			end
			if (exp_loss) begin
				void'(loss_q.pop_front());
			end
		end
	end

	task automatic fill_random();
		for (int i = 0; i < `PAYLOAD_LEN; i++) begin
			frame_pay[i] = byte_t'(rand_bits(8));
		end
	endtask

	// Drives len bytes of one frame, then the idle gap; a short len cuts the frame
	task automatic send_frame(input seg_num_t seg, input int len, input logic emit);
		byte_t b;
		int gap;
		for (int k = 0; k < len; k++) begin
			if (k == `SEG_OFFSET) begin
				b = seg[15:8];
			end else if (k == `SEG_OFFSET + 1) begin
				b = seg[7:0];
			end else if (k >= PAY_START && k < FRAME_LEN) begin
				b = frame_pay[k - PAY_START];
			end else begin
				b = byte_t'(rand_bits(8));
			end
			@(negedge rx_clk);
			rx_enable = 1'b1;
			rx_data = b;
			// The merged output lags the input byte by five pipeline registers
			if (emit && k >= PAY_START && k < FRAME_LEN) begin
				exp_cyc_q.push_back(cyc + 5);
				exp_data_q.push_back(expect_pay[k - PAY_START]);
			end
		end
		@(negedge rx_clk);
		rx_enable = 1'b0;
		rx_data = 8'h00;
		if (len < FRAME_LEN) begin
			loss_q.push_back(cyc + 2);
		end
		gap = 4 + int'(rand_bits(2));
		repeat (gap - 1) @(negedge rx_clk);
	endtask

	// Sends frame_pay as one complete copy and updates the model
	task automatic send_copy(input seg_num_t seg);
		int lane;
		logic emit;
		emit = 1'b0;
		if (seg < seg_num_t'(`SEGMENT_LANES)) begin
			lane = int'(seg);
			if (redundancy != vote_triple) begin
				expect_pay = frame_pay;
				emit = 1'b1;
			end else if (model_cnt[lane] < 2) begin
				model_copy[lane][model_cnt[lane]] = frame_pay;
				model_cnt[lane]++;
			end else begin
				for (int i = 0; i < `PAYLOAD_LEN; i++) begin
					expect_pay[i] = majority_of(model_copy[lane][0][i],
						model_copy[lane][1][i], frame_pay[i]);
				end
				model_cnt[lane] = 0;
				emit = 1'b1;
			end
		end
		send_frame(seg, FRAME_LEN + int'(rand_bits(2)), emit);
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (exp_cyc_q.size() != 0 || loss_q.size() != 0) begin
			if (n >= limit) begin
				stop_on_error("Timeout: expected output bytes or loss pulses never appeared");
			end else begin
				@(negedge rx_clk);
				n++;
			end
		end
	endtask

	initial begin : stimulus
		int lane;
		int k;
		int sent [`SEGMENT_LANES];
		byte_t base [`SEGMENT_LANES][`PAYLOAD_LEN];
		logic [1:0] flip_copy [`SEGMENT_LANES][`PAYLOAD_LEN];
		byte_t flip_mask [`SEGMENT_LANES][`PAYLOAD_LEN];
		lfsr_state = 32'h6a3d_bb0d;
		rst_n = 1'b0;
		rx_enable = 1'b0;
		rx_data = 8'h00;
		redundancy = vote_single;
		for (int l = 0; l < `SEGMENT_LANES; l++) begin
			model_cnt[l] = 0;
		end
		repeat (8) @(negedge rx_clk);
		rst_n = 1'b1;
		repeat (20) @(negedge rx_clk);

		// Single copies; an unknown redundancy code must behave the same way
		for (int n = 0; n < 24; n++) begin
			if (n == 12) begin
				redundancy = vote_mode_t'(2'd0);
			end
			fill_random();
			if (rand_bits(3) == 0) begin
				// Cut before the first payload byte, since a single copy is always final
				send_frame(seg_num_t'(rand_bits(2)), 1 + int'(rand_bits(3)) % PAY_START, 1'b0);
			end
			if (rand_bits(3) < 6) begin
				send_copy(seg_num_t'(rand_bits(2)));
			end else begin
				send_copy(far_seg());
			end
		end
		wait_idle(DRAIN_LIMIT);

		// Interleaved triple copies; the second round also cuts non-final copies short
		redundancy = vote_triple;
		for (int round = 0; round < 2; round++) begin
			for (int l = 0; l < `SEGMENT_LANES; l++) begin
				sent[l] = 0;
				for (int i = 0; i < `PAYLOAD_LEN; i++) begin
					base[l][i] = byte_t'(rand_bits(8));
					flip_copy[l][i] = 2'(rand_bits(2));
					flip_mask[l][i] = byte_t'(rand_bits(8));
				end
			end
			for (int step = 0; step < 3 * `SEGMENT_LANES; step++) begin
				lane = int'(rand_bits(2)) % `SEGMENT_LANES;
				while (sent[lane] == 3) begin
					lane = (lane + 1) % `SEGMENT_LANES;
				end
				k = sent[lane];
				if (round == 1 && k < 2 && rand_bits(1) == 1) begin
					fill_random();
					send_frame(seg_num_t'(lane), 1 + int'(rand_bits(5)) % (FRAME_LEN - 1), 1'b0);
				end
				if (rand_bits(2) == 0) begin
					fill_random();
					if (rand_bits(1) == 1) begin
						send_copy(far_seg());
					end else begin
						send_frame(far_seg(), 1 + int'(rand_bits(5)) % (FRAME_LEN - 1), 1'b0);
					end
				end
				// At most one copy is flipped at each byte position
				for (int i = 0; i < `PAYLOAD_LEN; i++) begin
					frame_pay[i] = base[lane][i] ^ ((flip_copy[lane][i] == 2'(k)) ?
						flip_mask[lane][i] : 8'h00);
				end
				send_copy(seg_num_t'(lane));
				sent[lane]++;
			end
			wait_idle(DRAIN_LIMIT);
		end

		repeat (10) @(negedge rx_clk);
		if (exp_cyc_q.size() != 0 || loss_q.size() != 0) begin
			stop_on_error("Expected output bytes were left over at the end of the run");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: rx_majority.f
+incdir+source
source/rx_frame_pkg.sv
source/rx_vote_pkg.sv
source/rx_frame_parser.sv
source/segment_router.sv
source/majority_voter.sv
source/lane_merge.sv
source/rx_majority_top.sv
bench/rx_majority_tb.sv
